/* cpu_cfg.svh */
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Program memory depth in bytes.
`define CPU_MEM_BYTES 256

// Scancode FIFO depth.
`define CPU_KEY_FIFO_DEPTH 5

// One operation byte plus two operands.
`define CPU_INSTR_BYTES 9
`define CPU_OPERAND_BYTES 4

// Vector table size and the slot used by the keyboard interrupt.
`define CPU_NUM_VECTORS 4
`define CPU_KEY_VECTOR 1

`endif

/* cpu_types_pkg.sv */
`include "cpu_cfg.svh"

package cpu_types_pkg;

    // Byte address, also used for the instruction pointer.
    typedef logic [31:0] addr_t;

    // Memory byte or keyboard scancode.
    typedef logic [7:0] byte_t;

    typedef logic [8*`CPU_OPERAND_BYTES-1:0] operand_t;
    typedef logic [7:0] opcode_t;
    typedef logic [$clog2(`CPU_NUM_VECTORS)-1:0] vec_idx_t;

endpackage

/* cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

    // Main controller states.
    typedef enum logic [1:0] {
        ST_LOAD,
        ST_FETCH,
        ST_EXECUTE,
        ST_DISPATCH
    } ctrl_state_e;

    // Write vector table entry operand1 with operand2.
    localparam cpu_types_pkg::opcode_t OP_SETIV = 8'd1;

    // Return from the running handler.
    localparam cpu_types_pkg::opcode_t OP_RETI = 8'd2;

    // Jump to code start plus operand1.
    localparam cpu_types_pkg::opcode_t OP_JMP = 8'd3;

endpackage

/* program_mem.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module program_mem (
    input  logic                 CLOCK_50,
    input  logic                 wr_en_i,
    input  cpu_types_pkg::addr_t wr_addr_i,
    input  cpu_types_pkg::byte_t wr_data_i,
    input  cpu_types_pkg::addr_t rd_addr_i,
    output cpu_types_pkg::byte_t rd_data_o
);
    import cpu_types_pkg::*;

    localparam int AW = $clog2(`CPU_MEM_BYTES);

    byte_t mem [`CPU_MEM_BYTES];

    always_ff @(posedge CLOCK_50)
    begin
        if (wr_en_i)
        begin
            mem[wr_addr_i[AW-1:0]] <= wr_data_i;
        end
        // Fetches that run past the top of memory wrap around.
        rd_data_o <= mem[rd_addr_i[AW-1:0]];
    end

    // The program image must fit the memory.
    assert property (@(posedge CLOCK_50) wr_en_i |-> wr_addr_i < addr_t'(`CPU_MEM_BYTES))
        else $error("program_mem: write address %0d out of range", wr_addr_i);

endmodule

/* sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  logic             CLOCK_50,
    input  logic             rst_n_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o,
    output logic             full_o
);
    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] buf_q [DEPTH];
    logic [PW-1:0]    wr_ptr_q;
    logic [PW-1:0]    rd_ptr_q;
    logic [CW-1:0]    count_q;
    logic             do_push;
    logic             do_pop;

    // Pointers wrap at DEPTH, which need not be a power of two.
    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        return (ptr == PW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty_o = (count_q == '0);
    assign full_o = (count_q == CW'(DEPTH));
    assign do_push = push_i && !full_o;
    assign do_pop = pop_i && !empty_o;

    // Head entry is visible before it is popped.
    assign pop_data_o = buf_q[rd_ptr_q];

    always_ff @(posedge CLOCK_50)
    begin
        if (do_push)
        begin
            buf_q[wr_ptr_q] <= push_data_i;
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end
        else
        begin
            if (do_push)
            begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop)
            begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            if (do_push && !do_pop)
            begin
                count_q <= count_q + 1'b1;
            end
            else if (do_pop && !do_push)
            begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assert property (@(posedge CLOCK_50) disable iff (!rst_n_i) !(pop_i && empty_o))
        else $error("sync_fifo: pop while empty");

    // A scancode arriving on a full queue is lost.
    assert property (@(posedge CLOCK_50) disable iff (!rst_n_i) !(push_i && full_o))
        else $error("sync_fifo: push while full, entry dropped");

endmodule

/* instr_assembler.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module instr_assembler (
    input  logic                    CLOCK_50,
    input  logic                    rst_n_i,
    input  logic                    byte_strobe_i,
    input  cpu_types_pkg::byte_t    byte_i,
    output logic [3:0]              byte_idx_o,
    output logic                    instr_full_o,
    output cpu_types_pkg::opcode_t  op_o,
    output cpu_types_pkg::operand_t operand1_o,
    output cpu_types_pkg::operand_t operand2_o
);
    import cpu_types_pkg::*;

    localparam logic [3:0] LAST_IDX = 4'(`CPU_INSTR_BYTES - 1);
    localparam logic [3:0] OP2_IDX = 4'(1 + `CPU_OPERAND_BYTES);

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            byte_idx_o <= '0;
            instr_full_o <= 1'b0;
        end
        else if (byte_strobe_i)
        begin
            // Full after the ninth byte, cleared by the first byte of the next one.
            instr_full_o <= (byte_idx_o == LAST_IDX);
            byte_idx_o <= (byte_idx_o == LAST_IDX) ? '0 : byte_idx_o + 4'd1;
        end
    end

    // Operand bytes enter at the top, so little-endian words end up in place.
    always_ff @(posedge CLOCK_50)
    begin
        if (byte_strobe_i)
        begin
            if (byte_idx_o == '0)
            begin
                op_o <= opcode_t'(byte_i);
            end
            else if (byte_idx_o < OP2_IDX)
            begin
                operand1_o <= {byte_i, operand1_o[$bits(operand_t)-1:8]};
            end
            else
            begin
                operand2_o <= {byte_i, operand2_o[$bits(operand_t)-1:8]};
            end
        end
    end

endmodule

/* interrupt_unit.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module interrupt_unit (
    input  logic                    CLOCK_50,
    input  logic                    rst_n_i,
    input  logic                    set_vector_i,
    input  cpu_types_pkg::vec_idx_t vec_idx_i,
    input  cpu_types_pkg::operand_t vec_addr_i,
    input  logic                    dispatch_i,
    input  cpu_types_pkg::addr_t    cur_ip_i,
    input  cpu_types_pkg::addr_t    code_start_i,
    input  cpu_types_pkg::addr_t    prog_end_i,
    input  cpu_types_pkg::byte_t    key_code_i,
    input  logic                    return_i,
    output cpu_types_pkg::addr_t    handler_ip_o,
    output cpu_types_pkg::addr_t    return_ip_o,
    output logic                    in_isr_o,
    output cpu_types_pkg::byte_t    isr_value_o
);
    import cpu_types_pkg::*;

    operand_t vector_q [`CPU_NUM_VECTORS];
    addr_t    next_ip;

    assign next_ip = cur_ip_i + addr_t'(`CPU_INSTR_BYTES);

    // Vector entries are offsets from the start of the code section.
    assign handler_ip_o = code_start_i + addr_t'(vector_q[`CPU_KEY_VECTOR]);

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < `CPU_NUM_VECTORS; i++)
            begin
                vector_q[i] <= '0;
            end
            in_isr_o <= 1'b0;
        end
        else
        begin
            if (set_vector_i)
            begin
                vector_q[vec_idx_i] <= vec_addr_i;
            end
            if (dispatch_i)
            begin
                in_isr_o <= 1'b1;
            end
            else if (return_i)
            begin
                in_isr_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50)
    begin
        if (dispatch_i)
        begin
            // Never return past the end of the program.
            return_ip_o <= (next_ip >= prog_end_i) ? cur_ip_i : next_ip;
            isr_value_o <= key_code_i;
        end
    end

    // Handlers do not nest.
    assert property (@(posedge CLOCK_50) disable iff (!rst_n_i) dispatch_i |-> !in_isr_o)
        else $error("interrupt_unit: dispatch while a handler is running");

endmodule

/* cpu_control.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_control (
    input  logic                    CLOCK_50,
    input  logic                    rst_n_i,
    input  logic                    load_valid_i,
    input  cpu_types_pkg::byte_t    load_byte_i,
    input  logic                    load_last_i,
    output logic                    mem_wr_en_o,
    output cpu_types_pkg::addr_t    mem_wr_addr_o,
    output cpu_types_pkg::byte_t    mem_wr_data_o,
    output cpu_types_pkg::addr_t    mem_rd_addr_o,
    output logic                    byte_strobe_o,
    input  logic [3:0]              byte_idx_i,
    input  logic                    instr_full_i,
    input  cpu_types_pkg::opcode_t  op_i,
    input  cpu_types_pkg::operand_t operand1_i,
    input  logic                    fifo_empty_i,
    output logic                    fifo_pop_o,
    input  logic                    in_isr_i,
    input  cpu_types_pkg::addr_t    handler_ip_i,
    input  cpu_types_pkg::addr_t    return_ip_i,
    output logic                    set_vector_o,
    output logic                    dispatch_o,
    output logic                    return_o,
    output cpu_types_pkg::addr_t    code_start_o,
    output cpu_types_pkg::addr_t    prog_end_o,
    output cpu_types_pkg::addr_t    ip_o,
    output logic                    instr_valid_o,
    output logic                    load_done_o
);
    import cpu_types_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam logic [3:0] LAST_IDX = 4'(`CPU_INSTR_BYTES - 1);

    ctrl_state_e state_q;
    addr_t       load_addr_q;
    operand_t    data_len_q;
    logic        rd_pending_q;
    logic        issue_rd;
    logic        exec;
    logic [3:0]  fetch_pos;
    addr_t       code_start_next;

    // Byte position of the next read, counting the one still in flight.
    assign fetch_pos = byte_idx_i + {3'b000, rd_pending_q};
    assign issue_rd = (state_q == ST_FETCH) && (fetch_pos <= LAST_IDX);
    assign mem_rd_addr_o = ip_o + addr_t'(fetch_pos);
    assign byte_strobe_o = rd_pending_q;

    assign mem_wr_en_o = (state_q == ST_LOAD) && load_valid_i;
    assign mem_wr_addr_o = load_addr_q;
    assign mem_wr_data_o = load_byte_i;

    // The code section follows the data section and its length word.
    assign code_start_next = addr_t'(data_len_q) + addr_t'(`CPU_OPERAND_BYTES);

    assign exec = (state_q == ST_EXECUTE) && instr_full_i;
    assign instr_valid_o = exec;
    assign set_vector_o = exec && (op_i == OP_SETIV);
    assign return_o = exec && (op_i == OP_RETI);
    assign fifo_pop_o = (state_q == ST_DISPATCH);
    assign dispatch_o = (state_q == ST_DISPATCH);

    always_ff @(posedge CLOCK_50)
    begin
        if (!rst_n_i)
        begin
            state_q <= ST_LOAD;
            load_addr_q <= '0;
            rd_pending_q <= 1'b0;
            load_done_o <= 1'b0;
            code_start_o <= '0;
            prog_end_o <= '0;
            ip_o <= '0;
        end
        else
        begin
            rd_pending_q <= issue_rd;
            case (state_q)
                ST_LOAD:
                begin
                    if (load_valid_i)
                    begin
                        load_addr_q <= load_addr_q + 1'b1;
                        if (load_last_i)
                        begin
                            code_start_o <= code_start_next;
                            prog_end_o <= load_addr_q + 1'b1;
                            ip_o <= code_start_next;
                            load_done_o <= 1'b1;
                            state_q <= ST_FETCH;
                        end
                    end
                end
                ST_FETCH:
                begin
                    if (byte_strobe_o && (byte_idx_i == LAST_IDX))
                    begin
                        state_q <= ST_EXECUTE;
                    end
                end
                ST_EXECUTE:
                begin
                    if (instr_full_i)
                    begin
                        // SETIV and all unknown opcodes just step to the next instruction.
                        case (op_i)
                            OP_RETI: ip_o <= return_ip_i;
                            OP_JMP: ip_o <= code_start_o + addr_t'(operand1_i);
                            default: ip_o <= ip_o + addr_t'(`CPU_INSTR_BYTES);
                        endcase
                        if (!fifo_empty_i && !in_isr_i)
                        begin
                            state_q <= ST_DISPATCH;
                        end
                        else
                        begin
                            state_q <= ST_FETCH;
                        end
                    end
                end
                ST_DISPATCH:
                begin
                    ip_o <= handler_ip_i;
                    state_q <= ST_FETCH;
                end
                default:
                begin
                    state_q <= ST_LOAD;
                end
            endcase
        end
    end

    // The length word is only captured from the first four load bytes.
    always_ff @(posedge CLOCK_50)
    begin
        if ((state_q == ST_LOAD) && load_valid_i && (load_addr_q < `CPU_OPERAND_BYTES))
        begin
            data_len_q <= {load_byte_i, data_len_q[$bits(operand_t)-1:8]};
        end
    end

    // A dispatch always has a scancode waiting at the FIFO head.
    assert property (@(posedge CLOCK_50) disable iff (!rst_n_i)
        (state_q == ST_DISPATCH) |-> !fifo_empty_i)
        else $error("cpu_control: dispatch with an empty scancode FIFO");

endmodule

/* cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpu_top (
    input  logic                    CLOCK_50,
    input  logic                    rst_n_i,
    input  logic                    load_valid_i,
    input  cpu_types_pkg::byte_t    load_byte_i,
    input  logic                    load_last_i,
    input  logic                    key_valid_i,
    input  cpu_types_pkg::byte_t    key_code_i,
    output logic                    instr_valid_o,
    output cpu_types_pkg::addr_t    instr_ip_o,
    output cpu_types_pkg::opcode_t  instr_op_o,
    output cpu_types_pkg::operand_t instr_operand1_o,
    output cpu_types_pkg::operand_t instr_operand2_o,
    output logic                    in_isr_o,
    output cpu_types_pkg::byte_t    isr_value_o,
    output logic                    load_done_o
);
    import cpu_types_pkg::*;

    logic       mem_wr_en;
    addr_t      mem_wr_addr;
    byte_t      mem_wr_data;
    addr_t      mem_rd_addr;
    byte_t      mem_rd_data;
    logic       byte_strobe;
    logic [3:0] byte_idx;
    logic       instr_full;
    logic       fifo_empty;
    logic       fifo_pop;
    byte_t      fifo_data;
    addr_t      handler_ip;
    addr_t      return_ip;
    logic       set_vector;
    logic       dispatch;
    logic       isr_return;
    addr_t      code_start;
    addr_t      prog_end;

    cpu_control cpu_control_i (
        .CLOCK_50(CLOCK_50), .rst_n_i(rst_n_i),
        .load_valid_i(load_valid_i), .load_byte_i(load_byte_i), .load_last_i(load_last_i),
        .mem_wr_en_o(mem_wr_en), .mem_wr_addr_o(mem_wr_addr), .mem_wr_data_o(mem_wr_data),
        .mem_rd_addr_o(mem_rd_addr), .byte_strobe_o(byte_strobe), .byte_idx_i(byte_idx),
        .instr_full_i(instr_full), .op_i(instr_op_o), .operand1_i(instr_operand1_o),
        .fifo_empty_i(fifo_empty), .fifo_pop_o(fifo_pop), .in_isr_i(in_isr_o),
        .handler_ip_i(handler_ip), .return_ip_i(return_ip), .set_vector_o(set_vector),
        .dispatch_o(dispatch), .return_o(isr_return), .code_start_o(code_start),
        .prog_end_o(prog_end), .ip_o(instr_ip_o), .instr_valid_o(instr_valid_o),
        .load_done_o(load_done_o)
    );

    program_mem program_mem_i (
        .CLOCK_50(CLOCK_50), .wr_en_i(mem_wr_en), .wr_addr_i(mem_wr_addr),
        .wr_data_i(mem_wr_data), .rd_addr_i(mem_rd_addr), .rd_data_o(mem_rd_data)
    );

    sync_fifo #(.WIDTH($bits(byte_t)), .DEPTH(`CPU_KEY_FIFO_DEPTH)) key_fifo (
        .CLOCK_50(CLOCK_50), .rst_n_i(rst_n_i), .push_i(key_valid_i),
        .push_data_i(key_code_i), .pop_i(fifo_pop), .pop_data_o(fifo_data),
        .empty_o(fifo_empty), .full_o()
    );

    instr_assembler instr_assembler_i (
        .CLOCK_50(CLOCK_50), .rst_n_i(rst_n_i), .byte_strobe_i(byte_strobe),
        .byte_i(mem_rd_data), .byte_idx_o(byte_idx), .instr_full_o(instr_full),
        .op_o(instr_op_o), .operand1_o(instr_operand1_o), .operand2_o(instr_operand2_o)
    );

    // SETIV takes the table index from operand1 and the entry from operand2.
    interrupt_unit interrupt_unit_i (
        .CLOCK_50(CLOCK_50), .rst_n_i(rst_n_i), .set_vector_i(set_vector),
        .vec_idx_i(instr_operand1_o[$bits(vec_idx_t)-1:0]), .vec_addr_i(instr_operand2_o),
        .dispatch_i(dispatch), .cur_ip_i(instr_ip_o), .code_start_i(code_start),
        .prog_end_i(prog_end), .key_code_i(fifo_data), .return_i(isr_return),
        .handler_ip_o(handler_ip), .return_ip_o(return_ip), .in_isr_o(in_isr_o),
        .isr_value_o(isr_value_o)
    );

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 20
) (
    output logic CLOCK_50
);
    initial
    begin
        CLOCK_50 = 1'b0;
        forever
        begin
            #(PERIOD_NS / 2) CLOCK_50 = ~CLOCK_50;
        end
    end

endmodule

/* tb_cpu_top.sv */
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module tb_cpu_top;
    import cpu_types_pkg::*;
    import cpu_ctrl_pkg::*;

    localparam int DATA_LEN = 7;
    localparam int NUM_KEYS = 8;
    localparam int TAIL_INSTRS = 4;

    logic     CLOCK_50;
    logic     rst_n_i;
    logic     load_valid_i;
    byte_t    load_byte_i;
    logic     load_last_i;
    logic     key_valid_i;
    byte_t    key_code_i;
    logic     instr_valid_o;
    addr_t    instr_ip_o;
    opcode_t  instr_op_o;
    operand_t instr_operand1_o;
    operand_t instr_operand2_o;
    logic     in_isr_o;
    byte_t    isr_value_o;
    logic     load_done_o;

    byte_t       image [$];
    byte_t       key_q [$];
    operand_t    vectors [`CPU_NUM_VECTORS];
    addr_t       code_start;
    addr_t       prog_end;
    addr_t       model_ip;
    addr_t       saved_ip;
    logic        model_in_isr;
    byte_t       model_isr_value;
    logic [31:0] lfsr;
    int          instr_count;
    int          dispatched;
    int          tail_count;
    logic        run_done;

    tb_clock_gen clock_gen_i (.CLOCK_50(CLOCK_50));

    cpu_top cpu_top_i (
        .CLOCK_50(CLOCK_50), .rst_n_i(rst_n_i),
        .load_valid_i(load_valid_i), .load_byte_i(load_byte_i), .load_last_i(load_last_i),
        .key_valid_i(key_valid_i), .key_code_i(key_code_i),
        .instr_valid_o(instr_valid_o), .instr_ip_o(instr_ip_o), .instr_op_o(instr_op_o),
        .instr_operand1_o(instr_operand1_o), .instr_operand2_o(instr_operand2_o),
        .in_isr_o(in_isr_o), .isr_value_o(isr_value_o), .load_done_o(load_done_o)
    );

    // Galois LFSR stepped once for every random bit.
    function automatic int random_bits(input int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++)
        begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
        end
        return value;
    endfunction

    function automatic void add_instr(input opcode_t op, input operand_t op1,
                                      input operand_t op2);
        image.push_back(byte_t'(op));
        for (int i = 0; i < `CPU_OPERAND_BYTES; i++)
        begin
            image.push_back(op1[8*i +: 8]);
        end
        for (int i = 0; i < `CPU_OPERAND_BYTES; i++)
        begin
            image.push_back(op2[8*i +: 8]);
        end
    endfunction

    // Little-endian word from the program image.
    function automatic operand_t image_word(input addr_t addr);
        operand_t word;
        for (int i = 0; i < `CPU_OPERAND_BYTES; i++)
        begin
            word[8*i +: 8] = image[addr + i];
        end
        return word;
    endfunction

    function automatic addr_t expected_next_ip(input addr_t ip, input opcode_t op,
                                               input operand_t op1);
        case (op)
            OP_JMP: return code_start + addr_t'(op1);
            OP_RETI: return saved_ip;
            default: return ip + addr_t'(`CPU_INSTR_BYTES);
        endcase
    endfunction

    // Return point saved at dispatch and held back at the program end.
    function automatic addr_t return_ip_for(input addr_t ip);
        return (ip + `CPU_INSTR_BYTES >= prog_end) ? ip : ip + addr_t'(`CPU_INSTR_BYTES);
    endfunction

    task automatic abort_run();
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (exp !== act)
        begin
            $display("Fail %s (instr %0d): expected 0x%08h, actual 0x%08h",
                     name, instr_count, exp, act);
            abort_run();
        end
    endtask

    task automatic check_opcode(input string name, input opcode_t exp, input opcode_t act);
        if (exp !== act)
        begin
            $display("Fail %s (instr %0d): expected 0x%02h, actual 0x%02h",
                     name, instr_count, exp, act);
            abort_run();
        end
    endtask

    task automatic check_operand(input string name, input operand_t exp, input operand_t act);
        if (exp !== act)
        begin
            $display("Fail %s (instr %0d): expected 0x%08h, actual 0x%08h",
                     name, instr_count, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act)
        begin
            $display("Fail %s (instr %0d): expected 0x%02h, actual 0x%02h",
                     name, instr_count, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (exp !== act)
        begin
            $display("Fail %s (instr %0d): expected %b, actual %b",
                     name, instr_count, exp, act);
            abort_run();
        end
    endtask

    // Header word, filler data, then the code section.
    task automatic build_program();
        operand_t data_len;
        data_len = operand_t'(DATA_LEN);
        for (int i = 0; i < `CPU_OPERAND_BYTES; i++)
        begin
            image.push_back(data_len[8*i +: 8]);
        end
        for (int i = 0; i < DATA_LEN; i++)
        begin
            image.push_back(byte_t'(8'hd0 + i));
        end
        add_instr(OP_SETIV, `CPU_KEY_VECTOR, 32'd36);
        add_instr(8'h40, 32'h1234_5678, 32'ha5c3_e10f);
        add_instr(8'h7e, 32'h0000_beef, 32'hffff_ffff);
        add_instr(OP_JMP, 32'd54, 32'h0);
        // Key handler at offset 36.
        add_instr(8'h55, 32'hcafe_f00d, 32'h0000_0001);
        add_instr(OP_RETI, 32'h0, 32'h0);
        // Main loop at offset 54 whose jump is the last instruction.
        add_instr(8'h81, 32'h89ab_cdef, 32'h0102_0304);
        add_instr(8'h00, 32'h0, 32'h8000_0000);
        add_instr(OP_JMP, 32'd54, 32'h0);
    endtask

    task automatic check_instr();
        opcode_t  op;
        operand_t op1;
        addr_t    next_ip;
        logic     take_key;
        op = image[model_ip];
        op1 = image_word(model_ip + 1);
        check_addr("instr_ip", model_ip, instr_ip_o);
        check_opcode("instr_op", op, instr_op_o);
        check_operand("operand1", op1, instr_operand1_o);
        check_operand("operand2", image_word(model_ip + 1 + `CPU_OPERAND_BYTES), instr_operand2_o);
        check_flag("in_isr", model_in_isr, in_isr_o);
        if (model_in_isr)
        begin
            check_byte("isr_value", model_isr_value, isr_value_o);
        end
        // A key is taken only if no handler was running during this instruction.
        take_key = (key_q.size() != 0) && !model_in_isr;
        next_ip = expected_next_ip(model_ip, op, op1);
        if (op == OP_SETIV)
        begin
            vectors[vec_idx_t'(op1)] = image_word(model_ip + 1 + `CPU_OPERAND_BYTES);
        end
        if (op == OP_RETI)
        begin
            model_in_isr = 1'b0;
        end
        if (take_key)
        begin
            saved_ip = return_ip_for(next_ip);
            model_isr_value = key_q.pop_front();
            model_in_isr = 1'b1;
            dispatched++;
            next_ip = code_start + addr_t'(vectors[`CPU_KEY_VECTOR]);
        end
        model_ip = next_ip;
        instr_count++;
        if (dispatched == NUM_KEYS && !model_in_isr)
        begin
            tail_count++;
        end
        run_done = (tail_count >= TAIL_INSTRS);
    endtask

    // Mirror of the scancode FIFO where a push lands on the rising edge.
    always @(posedge CLOCK_50)
    begin
        if (rst_n_i && key_valid_i)
        begin
            key_q.push_back(key_code_i);
        end
    end

    always @(negedge CLOCK_50)
    begin
        if (rst_n_i && instr_valid_o)
        begin
            check_instr();
        end
    end

    initial
    begin
        rst_n_i = 1'b0;
        load_valid_i = 1'b0;
        load_byte_i = '0;
        load_last_i = 1'b0;
        key_valid_i = 1'b0;
        key_code_i = '0;
        lfsr = 32'hfe3;
        for (int i = 0; i < `CPU_NUM_VECTORS; i++)
        begin
            vectors[i] = '0;
        end
        saved_ip = '0;
        model_in_isr = 1'b0;
        model_isr_value = '0;
        instr_count = 0;
        dispatched = 0;
        tail_count = 0;
        run_done = 1'b0;
        build_program();
        code_start = addr_t'(DATA_LEN + `CPU_OPERAND_BYTES);
        prog_end = addr_t'(image.size());
        model_ip = code_start;
        repeat (8) @(negedge CLOCK_50);
        rst_n_i = 1'b1;
        for (int i = 0; i < image.size(); i++)
        begin
            check_flag("load_done before last byte", 1'b0, load_done_o);
            load_valid_i = 1'b1;
            load_byte_i = image[i];
            load_last_i = (i == image.size() - 1);
            @(negedge CLOCK_50);
        end
        load_valid_i = 1'b0;
        load_last_i = 1'b0;
        check_flag("load_done after last byte", 1'b1, load_done_o);
        while (!run_done)
        begin
            @(posedge CLOCK_50);
        end
        $display("*** PASSED ***");
        $finish;
    end

    // Scancode bursts of one to three keys that start once the queue has drained.
    initial
    begin
        int gap;
        int burst;
        int sent;
        sent = 0;
        @(posedge rst_n_i);
        while (instr_count < 2)
        begin
            @(posedge CLOCK_50);
        end
        while (sent < NUM_KEYS)
        begin
            while (key_q.size() != 0)
            begin
                @(posedge CLOCK_50);
            end
            gap = 20 + random_bits(7);
            burst = 1 + random_bits(2) % 3;
            repeat (gap) @(negedge CLOCK_50);
            for (int i = 0; (i < burst) && (sent < NUM_KEYS); i++)
            begin
                key_valid_i = 1'b1;
                key_code_i = byte_t'(random_bits(8));
                sent++;
                @(negedge CLOCK_50);
            end
            key_valid_i = 1'b0;
        end
    end

    initial
    begin
        int limit;
        @(posedge rst_n_i);
        limit = image.size() * 12 + NUM_KEYS * 400;
        repeat (limit) @(posedge CLOCK_50);
        $display("Timeout: the run did not finish within %0d cycles after reset.", limit);
        abort_run();
    end

endmodule

/* compile.f */
+incdir+.
cpu_types_pkg.sv
cpu_ctrl_pkg.sv
program_mem.sv
sync_fifo.sv
instr_assembler.sv
interrupt_unit.sv
cpu_control.sv
cpu_top.sv
tb_clock_gen.sv
tb_cpu_top.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_cpu_top -o tb_cpu_top
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_cpu_top)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found"
exit 1
